//--- Makefile
SRCS := $(shell grep -v '^+' sim.f) include/rv_iss.svh

obj_dir/Vtb_core: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f sim.f -o Vtb_core

run: obj_dir/Vtb_core
	@out="$$(./obj_dir/Vtb_core)"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- include/rv_iss.svh
`ifndef RV_ISS_SVH
`define RV_ISS_SVH

// instruction-level model of the core
// included in the testbench body after the rv_pkg import, which also sets MEM_DEPTH
word_t iss_regs [32];
word_t iss_pc;
word_t iss_mem [MEM_DEPTH];
logic  iss_halt;

// store made by the last retired instruction, be stays zero for other classes
word_t    iss_st_addr;
word_t    iss_st_data;
byte_en_t iss_st_be;

function automatic word_t iss_alu(input funct3_t f3, input logic sub_sra,
                                  input word_t a, input word_t b);
  word_t r;
  case (f3)
    F3_ADD:  r = sub_sra ? a - b : a + b;
    F3_SLL:  r = a << b[4:0];
    F3_SLT:  r = {31'b0, $signed(a) < $signed(b)};
    F3_SLTU: r = {31'b0, a < b};
    F3_XOR:  r = a ^ b;
    F3_OR:   r = a | b;
    F3_AND:  r = a & b;
    default: begin
      r = a >> b[4:0];
      if (sub_sra)
        r = $signed(a) >>> b[4:0];
    end
  endcase
  return r;
endfunction

task automatic iss_reset(input word_t reset_pc);
  foreach (iss_regs[i])
    iss_regs[i] = '0;
  iss_pc    = reset_pc;
  iss_halt  = 1'b0;
  iss_st_be = '0;
endtask

// retires the instruction at iss_pc
task automatic iss_step(input word_t insn);
  word_t       a, b, imm_i, imm_s, imm_b, imm_j, imm_u, addr, word, wr, next_pc;
  funct3_t     f3;
  logic [7:0]  bt;
  logic [15:0] hf;
  logic        we;
  logic        take;
  iss_st_be = '0;
  if (iss_halt)
    return;
  f3      = insn[14:12];
  a       = iss_regs[insn[19:15]];
  b       = iss_regs[insn[24:20]];
  imm_i   = {{20{insn[31]}}, insn[31:20]};
  imm_s   = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  imm_b   = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  imm_j   = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  imm_u   = {insn[31:12], 12'b0};
  we      = insn[6:0] inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_OP_IMM, OP_OP};
  wr      = '0;
  next_pc = iss_pc + 32'd4;
  case (insn[6:0])
    OP_LUI:    wr = imm_u;
    OP_AUIPC:  wr = iss_pc + imm_u;
    OP_OP_IMM: wr = iss_alu(f3, insn[30] && f3 == F3_SR, a, imm_i);
    OP_OP:     wr = iss_alu(f3, insn[30], a, b);
    OP_JAL: begin
      wr      = iss_pc + 32'd4;
      next_pc = iss_pc + imm_j;
    end
    OP_JALR: begin
      wr      = iss_pc + 32'd4;
      next_pc = (a + imm_i) & ~32'd1;
    end
    OP_BRANCH: begin
      // bit 2 picks a less-than test, bit 1 unsigned, bit 0 inverts
      take = f3[2] ? (f3[1] ? a < b : $signed(a) < $signed(b)) : a == b;
      if (take ^ f3[0])
        next_pc = iss_pc + imm_b;
    end
    OP_LOAD: begin
      addr = a + imm_i;
      word = iss_mem[(addr >> 2) % MEM_DEPTH];
      bt   = word[{addr[1:0], 3'b000} +: 8];
      hf   = word[{addr[1], 4'b0000} +: 16];
      case (f3)
        F3_BYTE:   wr = {{24{bt[7]}}, bt};
        F3_HALF:   wr = {{16{hf[15]}}, hf};
        F3_BYTE_U: wr = {24'b0, bt};
        F3_HALF_U: wr = {16'b0, hf};
        default:   wr = word;
      endcase
    end
    OP_STORE: begin
      addr        = a + imm_s;
      iss_st_addr = {addr[31:2], 2'b00};
      iss_st_data = (f3 == F3_BYTE) ? {4{b[7:0]}} : (f3 == F3_HALF) ? {2{b[15:0]}} : b;
      iss_st_be   = (f3 == F3_BYTE) ? 4'b0001 << addr[1:0] :
                    (f3 == F3_HALF) ? (addr[1] ? 4'b1100 : 4'b0011) :
                    (f3 == F3_WORD) ? 4'b1111 : 4'b0000;
      for (int i = 0; i < 4; i++) begin
        if (iss_st_be[i])
          iss_mem[(addr >> 2) % MEM_DEPTH][8*i +: 8] = iss_st_data[8*i +: 8];
      end
    end
    OP_SYSTEM: begin
      iss_halt = insn[31:7] == '0;
      if (iss_halt)
        next_pc = iss_pc;
    end
  endcase
  if (we && insn[11:7] != '0)
    iss_regs[insn[11:7]] = wr;
  iss_pc = {next_pc[31:2], 2'b00};
endtask

`endif

//--- dv/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;
  import rv_pkg::*;

  localparam int          MEM_DEPTH    = 256;
  localparam logic [15:0] SEED         = 16'd41035;
  localparam int          N_PROGRAMS   = 4;
  localparam int          RUN_CYCLES   = 400;
  localparam int          RESET_CYCLES = 16;
  localparam int          HOLD_CYCLES  = 4;
  localparam int          TIMEOUT_CYCLES = N_PROGRAMS * (RUN_CYCLES + RESET_CYCLES) + 100;
  localparam word_t       RESET_PC     = '0;

  `include "rv_iss.svh"

  logic     clk = 1'b0;
  logic     rst = 1'b1;
  word_t    pc;
  word_t    insn;
  word_t    dmem_addr;
  word_t    dmem_wdata;
  byte_en_t dmem_be;
  word_t    dmem_rdata;
  logic     halt;

  // both memories wrap on address bits 9 to 2
  word_t imem [MEM_DEPTH];
  word_t dmem [MEM_DEPTH];

  logic [15:0] lfsr_state = SEED;
  int          n_checks = 0;
  int          n_errors = 0;
  int          cycle_count = 0;

  rv_core #(.RESET_PC(RESET_PC)) i_dut (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .insn       (insn),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_be    (dmem_be),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  always #10 clk = ~clk;

  assign insn       = imem[pc[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (dmem_be[i])
        dmem[dmem_addr[9:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // registers limited to x0..x7 so results feed each other often
  function automatic word_t random_insn();
    logic [3:0]  cls;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm12;
    logic [12:0] boff;
    logic [20:0] joff;
    logic [6:0]  f7;
    word_t       w;
    cls   = 4'(rand_bits(4));
    rd    = {2'b00, 3'(rand_bits(3))};
    rs1   = {2'b00, 3'(rand_bits(3))};
    rs2   = {2'b00, 3'(rand_bits(3))};
    f3    = 3'(rand_bits(3));
    imm12 = 12'(rand_bits(12));
    case (cls)
      4'd0: w = {20'(rand_bits(20)), rd, OP_LUI};
      4'd1: w = {20'(rand_bits(20)), rd, OP_AUIPC};
      4'd2, 4'd3, 4'd4: begin
        // shifts take a 5-bit amount and set bit 30 only for SRAI
        if (f3 == F3_SLL)
          imm12 = {7'b0, imm12[4:0]};
        else if (f3 == F3_SR)
          imm12 = {1'b0, imm12[10], 5'b0, imm12[4:0]};
        w = {imm12, rs1, f3, rd, OP_OP_IMM};
      end
      4'd5, 4'd6, 4'd7: begin
        f7 = ((f3 == F3_ADD || f3 == F3_SR) && imm12[0]) ? FUNCT7_ALT : 7'b0;
        w  = {f7, rs2, rs1, f3, rd, OP_OP};
      end
      4'd8, 4'd9: begin
        // 010 and 011 are no branch codes and fold onto BEQ and BNE
        if (f3[2:1] == 2'b01)
          f3[1] = 1'b0;
        boff = {{5{imm12[7]}}, imm12[7:0]};
        w = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OP_BRANCH};
      end
      4'd10: begin
        joff = {{11{imm12[9]}}, imm12[9:0]};
        w = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OP_JAL};
      end
      4'd11: w = {imm12, rs1, 3'b000, rd, OP_JALR};
      4'd12, 4'd13: begin
        if (f3 == 3'd3 || f3[2:1] == 2'b11)
          f3 = F3_WORD;
        w = {imm12, rs1, f3, rd, OP_LOAD};
      end
      default: begin
        f3 = {1'b0, f3[1:0]};
        if (f3 == 3'd3)
          f3 = F3_WORD;
        w = {imm12[11:5], rs2, rs1, f3, imm12[4:0], OP_STORE};
      end
    endcase
    return w;
  endfunction

  task automatic compare_value(input string name, input word_t got, input word_t exp);
    n_checks++;
    assert (got === exp)
      else begin
        n_errors++;
        $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      end
  endtask

  // program and data for the next run
  // the model gets the same data
  task automatic load_program();
    foreach (imem[i])
      imem[i] = random_insn();
    imem[8'(rand_bits(8))] = {25'b0, OP_SYSTEM};
    foreach (iss_mem[i])
      iss_mem[i] = rand_bits(32);
    foreach (dmem[i])
      dmem[i] <= iss_mem[i];
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      if (i == 0)
        load_program();
      compare_value("dmem_be", {28'b0, dmem_be}, 32'b0);
      // the first edge with rst high has not passed yet at i == 0
      if (i > 0)
        compare_value("pc", pc, RESET_PC);
      @(posedge clk);
    end
    rst <= 1'b0;
    iss_reset(RESET_PC);
  endtask

  // the model steps once per cycle and is compared before the retiring edge
  task automatic run_program();
    word_t mask;
    int    after_halt;
    after_halt = 0;
    for (int cyc = 0; cyc < RUN_CYCLES && after_halt < HOLD_CYCLES; cyc++) begin
      @(negedge clk);
      compare_value("pc", pc, iss_pc);
      iss_step(imem[iss_pc[9:2]]);
      compare_value("halt", {31'b0, halt}, {31'b0, iss_halt});
      compare_value("dmem_be", {28'b0, dmem_be}, {28'b0, iss_st_be});
      if (iss_st_be != '0) begin
        mask = {{8{iss_st_be[3]}}, {8{iss_st_be[2]}}, {8{iss_st_be[1]}}, {8{iss_st_be[0]}}};
        compare_value("dmem_addr", dmem_addr, iss_st_addr);
        compare_value("dmem_wdata", dmem_wdata & mask, iss_st_data & mask);
      end
      if (iss_halt)
        after_halt++;
    end
  endtask

  initial begin
    foreach (imem[i])
      imem[i] = '0;
    foreach (dmem[i])
      dmem[i] <= '0;
    for (int p = 0; p < N_PROGRAMS; p++) begin
      apply_reset();
      run_program();
    end
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic             clk,
  input  logic             rst,
  output rv_pkg::word_t    pc,
  input  rv_pkg::word_t    insn,
  output rv_pkg::word_t    dmem_addr,
  output rv_pkg::word_t    dmem_wdata,
  output rv_pkg::byte_en_t dmem_be,
  input  rv_pkg::word_t    dmem_rdata,
  output logic             halt
);
  import rv_pkg::*;

  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  reg_idx_t rd_idx;
  word_t    imm;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    rd_val;
  word_t    alu_result;
  word_t    mem_addr;
  word_t    target;
  word_t    load_val;
  funct3_t  funct3;
  logic     alt;
  logic     rd_we;
  logic     redirect;
  logic     is_lui, is_auipc, is_alu_imm, is_alu_reg, is_branch;
  logic     is_jal, is_jalr, is_load, is_store, is_ecall;

  rv_fetch #(.RESET_PC(RESET_PC)) i_fetch (.*);

  rv_decode i_decode (.*);

  rv_regfile i_regfile (.*);

  rv_execute i_execute (.*);

  rv_lsu i_lsu (.*, .store_val(rs2_val));

  // jumps link to the next instruction
  assign rd_val = (is_jal || is_jalr) ? pc + 32'd4 : (is_load ? load_val : alu_result);
  assign halt   = is_ecall;

  // byte enables come only from a decoded store
  assert property (@(posedge clk) dmem_be != '0 |-> is_store)
    else $error("dmem_be %b without a store", dmem_be);

endmodule

`default_nettype wire

//--- hw/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  rv_pkg::word_t    insn,
  output rv_pkg::reg_idx_t rs1_idx,
  output rv_pkg::reg_idx_t rs2_idx,
  output rv_pkg::reg_idx_t rd_idx,
  output rv_pkg::word_t    imm,
  output rv_pkg::funct3_t  funct3,
  output logic             alt,
  output logic             rd_we,
  output logic             is_lui,
  output logic             is_auipc,
  output logic             is_alu_imm,
  output logic             is_alu_reg,
  output logic             is_branch,
  output logic             is_jal,
  output logic             is_jalr,
  output logic             is_load,
  output logic             is_store,
  output logic             is_ecall
);
  import rv_pkg::*;

  opcode_t    opcode;
  logic [6:0] funct7;

  assign opcode  = insn[6:0];
  assign rd_idx  = insn[11:7];
  assign funct3  = insn[14:12];
  assign rs1_idx = insn[19:15];
  assign rs2_idx = insn[24:20];
  assign funct7  = insn[31:25];

  // unknown opcodes raise no strobe and retire as no-ops
  assign is_lui     = opcode == OP_LUI;
  assign is_auipc   = opcode == OP_AUIPC;
  assign is_alu_imm = opcode == OP_OP_IMM;
  assign is_alu_reg = opcode == OP_OP;
  assign is_branch  = opcode == OP_BRANCH;
  assign is_jal     = opcode == OP_JAL;
  assign is_jalr    = opcode == OP_JALR;
  assign is_load    = opcode == OP_LOAD;
  assign is_store   = opcode == OP_STORE;
  assign is_ecall   = opcode == OP_SYSTEM && insn[31:7] == '0;

  // bit 30 picks SUB and SRA but never turns ADDI into a subtract
  assign alt = funct7 == FUNCT7_ALT &&
               (is_alu_reg || (is_alu_imm && funct3 == F3_SR));

  // writes to x0 are dropped here
  assign rd_we = (is_lui || is_auipc || is_alu_imm || is_alu_reg ||
                  is_jal || is_jalr || is_load) && rd_idx != '0;

  always_comb begin
    case (opcode)
      OP_STORE:         imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      OP_BRANCH:        imm = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
      OP_JAL:           imm = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
      OP_LUI, OP_AUIPC: imm = {insn[31:12], 12'b0};
      // I-type for loads, JALR and register-immediate ops
      default:          imm = {{20{insn[31]}}, insn[31:20]};
    endcase
  end

endmodule

`default_nettype wire

//--- hw/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  rv_pkg::word_t   pc,
  input  rv_pkg::word_t   rs1_val,
  input  rv_pkg::word_t   rs2_val,
  input  rv_pkg::word_t   imm,
  input  rv_pkg::funct3_t funct3,
  input  logic            alt,
  input  logic            is_lui,
  input  logic            is_auipc,
  input  logic            is_alu_imm,
  input  logic            is_alu_reg,
  input  logic            is_branch,
  input  logic            is_jal,
  input  logic            is_jalr,
  output rv_pkg::word_t   alu_result,
  output rv_pkg::word_t   mem_addr,
  output rv_pkg::word_t   target,
  output logic            redirect
);
  import rv_pkg::*;

  word_t      op_b;
  logic [4:0] shamt;
  word_t      sra_val;
  word_t      alu_out;
  word_t      pc_rel;
  logic       taken;

  assign op_b  = is_alu_reg ? rs2_val : imm;
  assign shamt = op_b[4:0];
  // kept apart so the shift sees a signed operand
  assign sra_val = $signed(rs1_val) >>> shamt;

  always_comb begin
    case (funct3)
      F3_ADD:  alu_out = alt ? rs1_val - op_b : rs1_val + op_b;
      F3_SLL:  alu_out = rs1_val << shamt;
      F3_SLT:  alu_out = {31'b0, $signed(rs1_val) < $signed(op_b)};
      F3_SLTU: alu_out = {31'b0, rs1_val < op_b};
      F3_XOR:  alu_out = rs1_val ^ op_b;
      F3_SR:   alu_out = alt ? sra_val : rs1_val >> shamt;
      F3_OR:   alu_out = rs1_val | op_b;
      F3_AND:  alu_out = rs1_val & op_b;
    endcase
  end

  assign pc_rel = pc + imm;

  always_comb begin
    if (is_lui) begin
      alu_result = imm;
    end else if (is_auipc) begin
      alu_result = pc_rel;
    end else if (is_alu_imm || is_alu_reg) begin
      alu_result = alu_out;
    end else begin
      alu_result = '0;
    end
  end

  always_comb begin
    case (funct3)
      F3_BEQ:  taken = rs1_val == rs2_val;
      F3_BNE:  taken = rs1_val != rs2_val;
      F3_BLT:  taken = $signed(rs1_val) < $signed(rs2_val);
      F3_BGE:  taken = $signed(rs1_val) >= $signed(rs2_val);
      F3_BLTU: taken = rs1_val < rs2_val;
      F3_BGEU: taken = rs1_val >= rs2_val;
      default: taken = 1'b0;
    endcase
  end

  // also the JALR base
  assign mem_addr = rs1_val + imm;
  assign target   = is_jalr ? {mem_addr[31:1], 1'b0} : pc_rel;
  assign redirect = is_jal || is_jalr || (is_branch && taken);

endmodule

`default_nettype wire

//--- hw/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          redirect,
  input  rv_pkg::word_t target,
  input  logic          halt,
  output rv_pkg::word_t pc
);
  import rv_pkg::*;

  word_t pc_next;

  // an ECALL holds the pc until the next reset
  always_comb begin
    if (halt) begin
      pc_next = pc;
    end else if (redirect) begin
      pc_next = target;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= {RESET_PC[31:2], 2'b00};
    end else begin
      pc <= {pc_next[31:2], 2'b00};
    end
  end

  assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

//--- hw/rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
  input  logic             rst,
  input  logic             is_load,
  input  logic             is_store,
  input  rv_pkg::funct3_t  funct3,
  input  rv_pkg::word_t    mem_addr,
  input  rv_pkg::word_t    store_val,
  input  rv_pkg::word_t    dmem_rdata,
  output rv_pkg::word_t    dmem_addr,
  output rv_pkg::word_t    dmem_wdata,
  output rv_pkg::byte_en_t dmem_be,
  output rv_pkg::word_t    load_val
);
  import rv_pkg::*;

  logic [1:0]  lane;
  byte_en_t    size_be;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  word_t       load_ext;

  assign lane      = mem_addr[1:0];
  assign dmem_addr = {mem_addr[31:2], 2'b00};

  // store data is copied into every lane the size covers
  always_comb begin
    case (funct3)
      F3_BYTE: begin
        size_be    = 4'b0001 << lane;
        dmem_wdata = {4{store_val[7:0]}};
      end
      F3_HALF: begin
        size_be    = lane[1] ? 4'b1100 : 4'b0011;
        dmem_wdata = {2{store_val[15:0]}};
      end
      F3_WORD: begin
        size_be    = 4'b1111;
        dmem_wdata = store_val;
      end
      default: begin
        size_be    = 4'b0000;
        dmem_wdata = store_val;
      end
    endcase
  end

  // nothing is written while the core sits in reset
  assign dmem_be = (is_store && !rst) ? size_be : 4'b0000;

  // halfwords follow address bit 1 only
  assign byte_sel = dmem_rdata[{lane, 3'b000} +: 8];
  assign half_sel = lane[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

  always_comb begin
    case (funct3)
      F3_BYTE:   load_ext = {{24{byte_sel[7]}}, byte_sel};
      F3_HALF:   load_ext = {{16{half_sel[15]}}, half_sel};
      F3_BYTE_U: load_ext = {24'b0, byte_sel};
      F3_HALF_U: load_ext = {16'b0, half_sel};
      default:   load_ext = dmem_rdata;
    endcase
  end

  assign load_val = is_load ? load_ext : '0;

endmodule

`default_nettype wire

//--- hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // widths with a meaning of their own
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [3:0]  byte_en_t;

  // major opcodes
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_OP_IMM = 7'b0010011;
  localparam opcode_t OP_OP     = 7'b0110011;
  localparam opcode_t OP_SYSTEM = 7'b1110011;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_LUI    = 7'b0110111;

  // load and store sizes
  localparam funct3_t F3_BYTE   = 3'b000;
  localparam funct3_t F3_HALF   = 3'b001;
  localparam funct3_t F3_WORD   = 3'b010;
  localparam funct3_t F3_BYTE_U = 3'b100;
  localparam funct3_t F3_HALF_U = 3'b101;

  // branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // ALU functions
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // funct7 for SUB and SRA
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

endpackage

`default_nettype wire

//--- hw/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  input  rv_pkg::reg_idx_t rd_idx,
  input  logic             rd_we,
  input  rv_pkg::word_t    rd_val,
  output rv_pkg::word_t    rs1_val,
  output rv_pkg::word_t    rs2_val
);
  import rv_pkg::*;

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we) begin
      regs[rd_idx] <= rd_val;
    end
  end

  assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

  assert property (@(posedge clk) disable iff (rst) rs1_idx == '0 |-> rs1_val == '0)
    else $error("x0 read returned %h", rs1_val);

  // decode filters x0 out of the write port
  assert property (@(posedge clk) disable iff (rst) rd_we |-> rd_idx != '0)
    else $error("write enable raised for x0");

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_lsu.sv
hw/rv_core.sv
dv/tb_core.sv
